//--- logic/astral_settings.svh
//////////////////////////////////////////////////////////////////////
// fixed chip-edge constants for the padframe and clock/reset block
// include wherever pad counts, register widths or the tick divider
// are needed
//////////////////////////////////////////////////////////////////////

`ifndef ASTRAL_SETTINGS_SVH
`define ASTRAL_SETTINGS_SVH

// 18 vertical plus 4 horizontal muxed pads
`define ASTRAL_NUM_PADS 22

`define ASTRAL_REG_ADDR_W 8
`define ASTRAL_REG_DATA_W 32

// reference cycles per real-time tick
`define ASTRAL_RT_DIV 100
`define ASTRAL_RST_SYNC_STAGES 2

`endif

//--- logic/astral_pad_pkg.sv
//////////////////////////////////////////////////////////////////////
// pad function encoding and per-pad vector types, shared by the
// configuration registers and the pad function mux
//////////////////////////////////////////////////////////////////////

`include "astral_settings.svh"

package astral_pad_pkg;

  // code 3 is reserved and rejected on write
  typedef enum logic [1:0] {
    PAD_FN_OFF  = 2'd0,
    PAD_FN_GPIO = 2'd1,
    PAD_FN_ALT  = 2'd2
  } pad_fn_e;

  // one bit per muxed pad
  typedef logic [`ASTRAL_NUM_PADS-1:0] pad_vec_t;

  typedef pad_fn_e [`ASTRAL_NUM_PADS-1:0] pad_fn_arr_t;

endpackage

//--- logic/astral_reg_pkg.sv
//////////////////////////////////////////////////////////////////////
// types for one configuration register access: opcode, address and
// data words as seen on the register bus
//////////////////////////////////////////////////////////////////////

`include "astral_settings.svh"

package astral_reg_pkg;

  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  // word address, one word per pad
  typedef logic [`ASTRAL_REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`ASTRAL_REG_DATA_W-1:0] reg_data_t;

endpackage

//--- logic/reg_bus_if.sv
//////////////////////////////////////////////////////////////////////
// register access bus between the top level and the pad config
// registers where ready is a single-cycle answer one cycle after valid
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface reg_bus_if;

  logic                      valid;
  astral_reg_pkg::reg_op_e   op;
  astral_reg_pkg::reg_addr_t addr;
  astral_reg_pkg::reg_data_t wdata;
  astral_reg_pkg::reg_data_t rdata;
  logic                      ready;
  logic                      error;

  // request side
  modport host (
    output valid, op, addr, wdata,
    input  rdata, ready, error
  );

  modport target (
    input  valid, op, addr, wdata,
    output rdata, ready, error
  );

endinterface

//--- logic/astral_clk_rst_strap.sv
//////////////////////////////////////////////////////////////////////
// chip-edge reset and timing control on the reference clock
// synchronizes the power-on reset, divides down a real-time tick
// and captures the boot straps once after each reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "astral_settings.svh"

module astral_clk_rst_strap (
  input  logic       ref_clk_i,
  input  logic       arst_n_i,
  input  logic [1:0] boot_mode_pad_i,
  input  logic       secure_boot_pad_i,
  output logic       rst_n_o,
  output logic [1:0] boot_mode_o,
  output logic       secure_boot_o,
  output logic       strap_valid_o,
  output logic       rt_tick_o
);

  localparam int unsigned CNT_W = $clog2(`ASTRAL_RT_DIV);

  logic [`ASTRAL_RST_SYNC_STAGES-1:0] rst_sync_q;
  logic [CNT_W-1:0]                   rt_cnt_q;
  logic                               rst_n;

  //////////////////////////////////////////////////////////////////////
  // reset synchronizer
  //////////////////////////////////////////////////////////////////////

  // asserts asynchronously and releases once the last stage fills
  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[`ASTRAL_RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign rst_n   = rst_sync_q[`ASTRAL_RST_SYNC_STAGES-1];
  assign rst_n_o = rst_n;

  //////////////////////////////////////////////////////////////////////
  // real-time tick
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge ref_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      rt_cnt_q  <= '0;
      rt_tick_o <= 1'b0;
    end else if (rt_cnt_q == CNT_W'(`ASTRAL_RT_DIV - 1)) begin
      rt_cnt_q  <= '0;
      rt_tick_o <= 1'b1;
    end else begin
      rt_cnt_q  <= rt_cnt_q + 1'b1;
      rt_tick_o <= 1'b0;
    end
  end

  // strap capture on the first edge out of reset only
  always_ff @(posedge ref_clk_i or negedge rst_n) begin
    if (!rst_n) begin
      boot_mode_o   <= 2'b00;
      secure_boot_o <= 1'b0;
      strap_valid_o <= 1'b0;
    end else if (!strap_valid_o) begin
      boot_mode_o   <= boot_mode_pad_i;
      secure_boot_o <= secure_boot_pad_i;
      strap_valid_o <= 1'b1;
    end
  end

  // tick is a strobe and never a level
  assert property (@(posedge ref_clk_i) disable iff (!rst_n)
    rt_tick_o |=> !rt_tick_o);

endmodule

//--- logic/pad_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// per-pad function registers behind the register bus
// one word per pad where bad addresses and the reserved code answer
// with error and leave the configuration alone
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "astral_settings.svh"

module pad_cfg_regs (
  input  logic                        ref_clk_i,
  input  logic                        rst_n_i,
  reg_bus_if.target                   reg_bus,
  output astral_pad_pkg::pad_fn_arr_t pad_fn_o
);

  localparam int unsigned IDX_W = $clog2(`ASTRAL_NUM_PADS);

  astral_pad_pkg::pad_fn_arr_t fn_q;
  logic                        accept;
  logic                        is_write;
  logic                        addr_ok;
  logic                        code_bad;
  logic [IDX_W-1:0]            idx;
  logic                        ready_q;
  logic                        error_q;
  astral_reg_pkg::reg_data_t   rdata_q;

  // the cycle with ready still belongs to the old access
  assign accept   = reg_bus.valid && !ready_q;
  assign is_write = (reg_bus.op == astral_reg_pkg::REG_WRITE);
  assign addr_ok  = (reg_bus.addr < astral_reg_pkg::reg_addr_t'(`ASTRAL_NUM_PADS));
  assign code_bad = is_write && (reg_bus.wdata[1:0] == 2'b11);
  assign idx      = reg_bus.addr[IDX_W-1:0];

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
      error_q <= 1'b0;
      for (int i = 0; i < `ASTRAL_NUM_PADS; i++) begin
        fn_q[i] <= astral_pad_pkg::PAD_FN_OFF;
      end
    end else begin
      ready_q <= accept;
      error_q <= accept && (!addr_ok || code_bad);
      // update lands on the same edge that raises ready
      if (accept && is_write && addr_ok && !code_bad) begin
        fn_q[idx] <= astral_pad_pkg::pad_fn_e'(reg_bus.wdata[1:0]);
      end
    end
  end

  // upper bits and unmapped words read as zero
  always_ff @(posedge ref_clk_i) begin
    if (accept) begin
      rdata_q <= '0;
      if (!is_write && addr_ok) begin
        rdata_q[1:0] <= fn_q[idx];
      end
    end
  end

  assign reg_bus.ready = ready_q;
  assign reg_bus.error = error_q;
  assign reg_bus.rdata = rdata_q;
  assign pad_fn_o      = fn_q;

  //////////////////////////////////////////////////////////////////////
  // bus protocol checks
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    reg_bus.ready |=> !reg_bus.ready);

  assert property (@(posedge ref_clk_i) disable iff (!rst_n_i)
    reg_bus.ready |-> $past(reg_bus.valid));

endmodule

//--- logic/pad_func_mux.sv
//////////////////////////////////////////////////////////////////////
// combinational padframe mux that sends each pad to GPIO, the
// alternate peripheral or off as its configured function selects
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "astral_settings.svh"

module pad_func_mux (
  input  astral_pad_pkg::pad_fn_arr_t pad_fn_i,
  input  astral_pad_pkg::pad_vec_t    gpio_out_i,
  input  astral_pad_pkg::pad_vec_t    gpio_oe_i,
  input  astral_pad_pkg::pad_vec_t    alt_out_i,
  input  astral_pad_pkg::pad_vec_t    alt_oe_i,
  input  astral_pad_pkg::pad_vec_t    pad_in_i,
  output astral_pad_pkg::pad_vec_t    gpio_in_o,
  output astral_pad_pkg::pad_vec_t    alt_in_o,
  output astral_pad_pkg::pad_vec_t    pad_out_o,
  output astral_pad_pkg::pad_vec_t    pad_oe_o
);

  astral_pad_pkg::pad_vec_t off_mask;

  always_comb begin
    gpio_in_o = '0;
    alt_in_o  = '0;
    pad_out_o = '0;
    pad_oe_o  = '0;
    for (int i = 0; i < `ASTRAL_NUM_PADS; i++) begin
      unique case (pad_fn_i[i])
        astral_pad_pkg::PAD_FN_GPIO: begin
          pad_out_o[i] = gpio_out_i[i];
          pad_oe_o[i]  = gpio_oe_i[i];
          gpio_in_o[i] = pad_in_i[i];
        end
        astral_pad_pkg::PAD_FN_ALT: begin
          pad_out_o[i] = alt_out_i[i];
          pad_oe_o[i]  = alt_oe_i[i];
          alt_in_o[i]  = pad_in_i[i];
        end
        // off and the reserved code leave the pad undriven
        default: ;
      endcase
    end
  end

  // pads configured off for the output enable check
  always_comb begin
    for (int i = 0; i < `ASTRAL_NUM_PADS; i++) begin
      off_mask[i] = (pad_fn_i[i] == astral_pad_pkg::PAD_FN_OFF);
    end
  end

  always_comb begin
    assert final ((pad_oe_o & off_mask) == '0);
  end

endmodule

//--- logic/astral_io_wrap.sv
//////////////////////////////////////////////////////////////////////
// chip-edge wrapper around reset and tick control, boot straps and
// the configurable padframe, with register access on plain ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module astral_io_wrap (
  input  logic                      ref_clk_i,
  input  logic                      arst_n_i,
  // boot straps
  input  logic [1:0]                boot_mode_pad_i,
  input  logic                      secure_boot_pad_i,
  output logic [1:0]                boot_mode_o,
  output logic                      secure_boot_o,
  output logic                      strap_valid_o,
  output logic                      rt_tick_o,
  // muxed pads and peripheral sides
  input  astral_pad_pkg::pad_vec_t  gpio_out_i,
  input  astral_pad_pkg::pad_vec_t  gpio_oe_i,
  input  astral_pad_pkg::pad_vec_t  alt_out_i,
  input  astral_pad_pkg::pad_vec_t  alt_oe_i,
  input  astral_pad_pkg::pad_vec_t  pad_in_i,
  output astral_pad_pkg::pad_vec_t  gpio_in_o,
  output astral_pad_pkg::pad_vec_t  alt_in_o,
  output astral_pad_pkg::pad_vec_t  pad_out_o,
  output astral_pad_pkg::pad_vec_t  pad_oe_o,
  // config register access
  input  logic                      reg_valid_i,
  input  astral_reg_pkg::reg_op_e   reg_op_i,
  input  astral_reg_pkg::reg_addr_t reg_addr_i,
  input  astral_reg_pkg::reg_data_t reg_wdata_i,
  output astral_reg_pkg::reg_data_t reg_rdata_o,
  output logic                      reg_ready_o,
  output logic                      reg_error_o
);

  logic                        rst_n;
  astral_pad_pkg::pad_fn_arr_t pad_fn;

  reg_bus_if reg_bus ();

  // host side of the register bus
  assign reg_bus.valid = reg_valid_i;
  assign reg_bus.op    = reg_op_i;
  assign reg_bus.addr  = reg_addr_i;
  assign reg_bus.wdata = reg_wdata_i;
  assign reg_rdata_o   = reg_bus.rdata;
  assign reg_ready_o   = reg_bus.ready;
  assign reg_error_o   = reg_bus.error;

  //////////////////////////////////////////////////////////////////////
  // clock and reset
  //////////////////////////////////////////////////////////////////////

  astral_clk_rst_strap i_clk_rst_strap (
    .ref_clk_i         ( ref_clk_i         ),
    .arst_n_i          ( arst_n_i          ),
    .boot_mode_pad_i   ( boot_mode_pad_i   ),
    .secure_boot_pad_i ( secure_boot_pad_i ),
    .rst_n_o           ( rst_n             ),
    .boot_mode_o       ( boot_mode_o       ),
    .secure_boot_o     ( secure_boot_o     ),
    .strap_valid_o     ( strap_valid_o     ),
    .rt_tick_o         ( rt_tick_o         )
  );

  //////////////////////////////////////////////////////////////////////
  // padframe
  //////////////////////////////////////////////////////////////////////

  pad_cfg_regs i_pad_cfg_regs (
    .ref_clk_i ( ref_clk_i ),
    .rst_n_i   ( rst_n     ),
    .reg_bus   ( reg_bus   ),
    .pad_fn_o  ( pad_fn    )
  );

  pad_func_mux i_pad_func_mux (
    .pad_fn_i   ( pad_fn     ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .alt_out_i  ( alt_out_i  ),
    .alt_oe_i   ( alt_oe_i   ),
    .pad_in_i   ( pad_in_i   ),
    .gpio_in_o  ( gpio_in_o  ),
    .alt_in_o   ( alt_in_o   ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   )
  );

endmodule

//--- bench/tb_astral_io_wrap.sv
//////////////////////////////////////////////////////////////////////
// testbench for the chip-edge wrapper that drives straps, register
// accesses and random pad traffic while assertions check results
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "astral_settings.svh"

module tb_astral_io_wrap;

  localparam int NP = `ASTRAL_NUM_PADS;
  localparam int TIMEOUT_CYCLES = 1000;

  logic                      ref_clk_i;
  logic                      arst_n_i;
  logic [1:0]                boot_mode_pad_i;
  logic [1:0]                boot_mode_o;
  logic                      secure_boot_pad_i;
  logic                      secure_boot_o;
  logic                      strap_valid_o;
  logic                      rt_tick_o;
  logic [NP-1:0]             gpio_out_i, gpio_oe_i, alt_out_i, alt_oe_i, pad_in_i;
  logic [NP-1:0]             gpio_in_o, alt_in_o, pad_out_o, pad_oe_o;
  logic                      reg_valid_i;
  logic                      reg_ready_o;
  logic                      reg_error_o;
  astral_reg_pkg::reg_op_e   reg_op_i;
  astral_reg_pkg::reg_addr_t reg_addr_i;
  astral_reg_pkg::reg_data_t reg_wdata_i;
  astral_reg_pkg::reg_data_t reg_rdata_o;

  // expected pad functions and straps
  logic [1:0] exp_fn [NP];
  logic [1:0] strap_boot_exp;
  logic       strap_sec_exp;
  int         tick_gap;
  int         tick_count;

  astral_io_wrap u_astral_io_wrap (.*);

  initial ref_clk_i = 1'b0;
  always #4 ref_clk_i = ~ref_clk_i;

  // cycles since the last tick
  always @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tick_gap   <= 0;
      tick_count <= 0;
    end else if (rt_tick_o) begin
      tick_gap   <= 1;
      tick_count <= tick_count + 1;
    end else begin
      tick_gap <= tick_gap + 1;
    end
  end

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", test, exp, act);
    stop_with_failure();
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    stop_with_failure();
  endtask

  task automatic check_value(input string test, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else report_mismatch(test, exp, act);
  endtask

  ////////////////////////////////////////////////////////////////////
  // timing checks
  ////////////////////////////////////////////////////////////////////

  assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    (rt_tick_o && tick_count > 0) |-> tick_gap == `ASTRAL_RT_DIV)
    else report_mismatch("rt tick spacing", `ASTRAL_RT_DIV, $sampled(tick_gap));

  assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    strap_valid_o |-> (boot_mode_o == strap_boot_exp) && (secure_boot_o == strap_sec_exp))
    else report_mismatch("strap hold", 32'({strap_sec_exp, strap_boot_exp}),
                         32'({$sampled(secure_boot_o), $sampled(boot_mode_o)}));

  assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    strap_valid_o |=> strap_valid_o)
    else report_failure("strap_valid_o dropped before the next reset");

  assert property (@(posedge ref_clk_i) disable iff (!arst_n_i)
    $rose(reg_valid_i) |=> reg_ready_o)
    else report_failure("register ready did not follow valid by one cycle");

  // entered and left 1 ns after a rising edge with one idle cycle after each access
  task automatic reg_access(input astral_reg_pkg::reg_op_e op, input int addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    waited      = 0;
    reg_op_i    = op;
    reg_addr_i  = astral_reg_pkg::reg_addr_t'(addr);
    reg_wdata_i = wdata;
    reg_valid_i = 1'b1;
    do begin
      @(posedge ref_clk_i);
      #1;
      waited++;
    end while (!reg_ready_o && waited < TIMEOUT_CYCLES);
    if (!reg_ready_o) report_failure("register access timed out waiting for ready");
    check_value("ready latency", 32'd1, 32'(waited));
    rdata       = reg_rdata_o;
    err         = reg_error_o;
    reg_valid_i = 1'b0;
    @(posedge ref_clk_i);
    #1;
  endtask

  task automatic read_back_all(input string test);
    logic [31:0] rdata;
    logic        err;
    for (int i = 0; i < NP; i++) begin
      reg_access(astral_reg_pkg::REG_READ, i, 32'd0, rdata, err);
      check_value({test, " error"}, 32'd0, 32'(err));
      check_value({test, " data"}, {30'd0, exp_fn[i]}, rdata);
    end
  endtask

  // random pad traffic checked at the falling edge once settled
  task automatic drive_and_check_routing(input string test);
    logic [NP-1:0] e_out, e_oe, e_gin, e_ain;
    gpio_out_i = NP'($urandom);
    gpio_oe_i  = NP'($urandom);
    alt_out_i  = NP'($urandom);
    alt_oe_i   = NP'($urandom);
    pad_in_i   = NP'($urandom);
    @(negedge ref_clk_i);
    e_out = '0;
    e_oe  = '0;
    e_gin = '0;
    e_ain = '0;
    for (int i = 0; i < NP; i++) begin
      case (exp_fn[i])
        astral_pad_pkg::PAD_FN_GPIO: begin
          e_out[i] = gpio_out_i[i];
          e_oe[i]  = gpio_oe_i[i];
          e_gin[i] = pad_in_i[i];
        end
        astral_pad_pkg::PAD_FN_ALT: begin
          e_out[i] = alt_out_i[i];
          e_oe[i]  = alt_oe_i[i];
          e_ain[i] = pad_in_i[i];
        end
        default: ;
      endcase
    end
    check_value({test, " pad_out"}, 32'(e_out), 32'(pad_out_o));
    check_value({test, " pad_oe"}, 32'(e_oe), 32'(pad_oe_o));
    check_value({test, " gpio_in"}, 32'(e_gin), 32'(gpio_in_o));
    check_value({test, " alt_in"}, 32'(e_ain), 32'(alt_in_o));
    @(posedge ref_clk_i);
    #1;
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [1:0]  code;
    int          idx;
    int          waited;
    void'($urandom(32'he702_35cf));
    arst_n_i     = 1'b0;
    reg_valid_i  = 1'b0;
    reg_op_i     = astral_reg_pkg::REG_READ;
    reg_addr_i   = '0;
    reg_wdata_i  = '0;
    gpio_out_i   = '0;
    gpio_oe_i    = '0;
    alt_out_i    = '0;
    alt_oe_i     = '0;
    pad_in_i     = '0;
    strap_boot_exp    = 2'($urandom);
    strap_sec_exp     = 1'($urandom);
    boot_mode_pad_i   = strap_boot_exp;
    secure_boot_pad_i = strap_sec_exp;
    for (int i = 0; i < NP; i++) begin
      exp_fn[i] = astral_pad_pkg::PAD_FN_OFF;
    end
    repeat (2) @(posedge ref_clk_i);
    #1;
    check_value("reset strap_valid", 32'd0, 32'(strap_valid_o));
    check_value("reset rt_tick", 32'd0, 32'(rt_tick_o));
    arst_n_i = 1'b1;

    // straps and then pad changes that must be ignored
    waited = 0;
    while (!strap_valid_o && waited < TIMEOUT_CYCLES) begin
      @(posedge ref_clk_i);
      #1;
      waited++;
    end
    if (!strap_valid_o) report_failure("strap_valid_o never rose after reset");
    check_value("strap boot_mode", 32'(strap_boot_exp), 32'(boot_mode_o));
    check_value("strap secure_boot", 32'(strap_sec_exp), 32'(secure_boot_o));
    check_value("reset reg_ready", 32'd0, 32'(reg_ready_o));
    check_value("reset reg_error", 32'd0, 32'(reg_error_o));
    boot_mode_pad_i   = ~strap_boot_exp;
    secure_boot_pad_i = ~strap_sec_exp;
    drive_and_check_routing("reset state");

    for (int i = 0; i < NP; i++) begin
      code = 2'($urandom % 3);
      reg_access(astral_reg_pkg::REG_WRITE, i, 32'(code), rdata, err);
      check_value("write error", 32'd0, 32'(err));
      exp_fn[i] = code;
    end
    read_back_all("readback");
    repeat (4) drive_and_check_routing("routing");

    ////////////////////////////////////////////////////////////////////
    // error responses
    ////////////////////////////////////////////////////////////////////
    idx = int'($urandom % NP);
    reg_access(astral_reg_pkg::REG_WRITE, idx, 32'd3, rdata, err);
    check_value("reserved code error", 32'd1, 32'(err));
    reg_access(astral_reg_pkg::REG_WRITE, NP, 32'd1, rdata, err);
    check_value("bad address write error", 32'd1, 32'(err));
    reg_access(astral_reg_pkg::REG_READ, NP, 32'd0, rdata, err);
    check_value("bad address read error", 32'd1, 32'(err));
    check_value("bad address read data", 32'd0, rdata);
    read_back_all("readback after errors");
    drive_and_check_routing("routing after errors");

    waited = 0;
    while (tick_count < 3 && waited < TIMEOUT_CYCLES) begin
      @(posedge ref_clk_i);
      #1;
      waited++;
    end
    if (tick_count < 3) report_failure("real-time tick stopped before three pulses");
    check_value("strap boot_mode at end", 32'(strap_boot_exp), 32'(boot_mode_o));

    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- astral_io_wrap.f
+incdir+logic
logic/astral_pad_pkg.sv
logic/astral_reg_pkg.sv
logic/reg_bus_if.sv
logic/astral_clk_rst_strap.sv
logic/pad_cfg_regs.sv
logic/pad_func_mux.sv
logic/astral_io_wrap.sv
bench/tb_astral_io_wrap.sv

//--- run_sim.sh
#!/bin/sh
# build and run the astral_io_wrap testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f astral_io_wrap.f \
  --top-module tb_astral_io_wrap -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_astral_io_wrap)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Result: PASSED"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
